// ==== logic/dcore_pack.sv ====
package dcore_pack;

    // lane and datapath widths
    localparam int Nti   = 4;
    localparam int Nadc  = 8;
    localparam int Nreg  = 16;

    // PRBS7, feedback from bits n-7 and n-6
    localparam int Nprbs = 7;

    // lane vectors used to fill the checker history before counting
    localparam int Nwarm = 2;

    // register map
    typedef logic [2:0] reg_addr_t;

    localparam reg_addr_t ADDR_CTRL    = 3'd0;
    localparam reg_addr_t ADDR_THRESH  = 3'd1;
    localparam reg_addr_t ADDR_OFFSET0 = 3'd2;
    localparam reg_addr_t ADDR_OFFSET1 = 3'd3;
    localparam reg_addr_t ADDR_OFFSET2 = 3'd4;
    localparam reg_addr_t ADDR_OFFSET3 = 3'd5;
    // counters, read only
    localparam reg_addr_t ADDR_TOTAL   = 3'd6;
    localparam reg_addr_t ADDR_ERRORS  = 3'd7;

    // control word layout, en_check sits in bit 0
    typedef struct packed {
        logic [12:0] reserved;
        logic        clear_cnt;
        logic        invert;
        logic        en_check;
    } ctrl_t;

    // one register word, seen either as control fields or as a signed value
    typedef union packed {
        ctrl_t                  ctrl;
        logic signed [Nreg-1:0] value;
    } reg_word_u;

    // unfolded ADC code, one bit wider than the magnitude
    typedef logic signed [Nadc:0] code_t;

endpackage

// ==== logic/dcore_cfg_intf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface dcore_cfg_intf;
    import dcore_pack::*;

    // configuration from the register block
    logic signed [Nreg-1:0] thresh;
    logic signed [Nreg-1:0] offset [Nti-1:0];
    logic                   invert;
    logic                   en_check;
    logic                   clear_cnt;

    // status back from the checker
    logic [Nreg-1:0] total_cnt;
    logic [Nreg-1:0] err_cnt;

    modport regs (
        output thresh, offset, invert, en_check, clear_cnt,
        input  total_cnt, err_cnt
    );

    modport unfold (
        input thresh, offset, invert
    );

    modport check (
        input  en_check, clear_cnt,
        output total_cnt, err_cnt
    );

endinterface

`default_nettype wire

// ==== logic/adc_unfold_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_unfold_slice (
    input  wire logic                         clk_adc_i,
    input  wire logic                         reset_i,
    input  wire logic [dcore_pack::Nadc-1:0]  adcout_i [dcore_pack::Nti-1:0],
    input  wire logic [dcore_pack::Nti-1:0]   adcout_sign_i,
    dcore_cfg_intf.unfold                     cfg_i,
    output logic      [dcore_pack::Nti-1:0]   rx_bits_o
);
    import dcore_pack::*;

    code_t          unfolded    [Nti-1:0];
    code_t          lane_offset [Nti-1:0];
    code_t          code_q      [Nti-1:0];
    code_t          thresh_code;
    logic [Nti-1:0] decision;

    // sign bit high means a positive sample
    always_comb begin
        for (int k = 0; k < Nti; k++) begin
            lane_offset[k] = $signed(cfg_i.offset[k][Nadc:0]);
            if (adcout_sign_i[k]) begin
                unfolded[k] = $signed({1'b0, adcout_i[k]});
            end else begin
                unfolded[k] = -$signed({1'b0, adcout_i[k]});
            end
        end
    end

    // stage 1: offset corrected code
    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            for (int k = 0; k < Nti; k++) begin
                code_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < Nti; k++) begin
                code_q[k] <= unfolded[k] - lane_offset[k];
            end
        end
    end

    // only the low bits of the threshold reach the slicer
    assign thresh_code = $signed(cfg_i.thresh[Nadc:0]);

    always_comb begin
        for (int k = 0; k < Nti; k++) begin
            decision[k] = (code_q[k] > thresh_code) ^ cfg_i.invert;
        end
    end

    // stage 2: sliced bits
    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            rx_bits_o <= '0;
        end else begin
            rx_bits_o <= decision;
        end
    end

endmodule

`default_nettype wire

// ==== logic/prbs_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module prbs_checker (
    input  wire logic                        clk_adc_i,
    input  wire logic                        reset_i,
    input  wire logic [dcore_pack::Nti-1:0]  rx_bits_i,
    dcore_cfg_intf.check                     cfg_i
);
    import dcore_pack::*;

    // hist_q[0] is the oldest received bit
    logic [Nprbs-1:0]         hist_q;
    logic [Nprbs+Nti-1:0]     seq;
    logic [Nti-1:0]           mismatch;
    logic [$clog2(Nti+1)-1:0] err_num;
    logic [1:0]               warm_q;
    logic                     counting;
    logic [Nreg:0]            total_sum;
    logic [Nreg:0]            err_sum;
    logic [Nreg-1:0]          total_q;
    logic [Nreg-1:0]          err_q;

    // serial order: history first, then lane 0 up to lane Nti-1
    assign seq = {rx_bits_i, hist_q};

    // bit n is predicted from bits n-7 and n-6 of the received stream
    always_comb begin
        err_num = '0;
        for (int k = 0; k < Nti; k++) begin
            mismatch[k] = rx_bits_i[k] ^ seq[k] ^ seq[k+1];
            if (mismatch[k]) begin
                err_num = err_num + 1'b1;
            end
        end
    end

    assign counting = cfg_i.en_check && (warm_q == Nwarm);

    // one extra bit to catch the overflow
    assign total_sum = {1'b0, total_q} + (Nreg+1)'(Nti);
    assign err_sum   = {1'b0, err_q} + (Nreg+1)'(err_num);

    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            hist_q <= '0;
        end else begin
            hist_q <= seq[Nprbs+Nti-1:Nti];
        end
    end

    // warm-up restarts whenever checking is off or the counters are cleared
    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            warm_q <= '0;
        end else if (cfg_i.clear_cnt || !cfg_i.en_check) begin
            warm_q <= '0;
        end else if (warm_q != Nwarm) begin
            warm_q <= warm_q + 1'b1;
        end
    end

    // saturating counters
    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            total_q <= '0;
            err_q   <= '0;
        end else if (cfg_i.clear_cnt) begin
            total_q <= '0;
            err_q   <= '0;
        end else if (counting) begin
            if (total_sum[Nreg]) begin
                total_q <= '1;
            end else begin
                total_q <= total_sum[Nreg-1:0];
            end
            if (err_sum[Nreg]) begin
                err_q <= '1;
            end else begin
                err_q <= err_sum[Nreg-1:0];
            end
        end
    end

    assign cfg_i.total_cnt = total_q;
    assign cfg_i.err_cnt   = err_q;

endmodule

`default_nettype wire

// ==== logic/dcore_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcore_regs (
    input  wire logic                        clk_adc_i,
    input  wire logic                        reset_i,
    input  wire logic                        reg_req_i,
    input  wire logic                        reg_we_i,
    input  wire dcore_pack::reg_addr_t       reg_addr_i,
    input  wire logic [dcore_pack::Nreg-1:0] reg_wdata_i,
    output logic                             reg_ack_o,
    output logic      [dcore_pack::Nreg-1:0] reg_rdata_o,
    dcore_cfg_intf.regs                      cfg_o
);
    import dcore_pack::*;

    reg_word_u              wr_word;
    reg_word_u              rd_word;
    logic                   en_check_q;
    logic                   invert_q;
    logic                   clear_q;
    logic signed [Nreg-1:0] thresh_q;
    logic signed [Nreg-1:0] offset_q [Nti-1:0];
    logic                   ack_q;
    logic [Nreg-1:0]        rdata_q;
    logic                   start;
    logic                   wr_en;

    // request taken once on the first edge with req high and ack low
    assign start   = reg_req_i && !ack_q;
    assign wr_en   = start && reg_we_i;
    assign wr_word = reg_wdata_i;

    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else if (start) begin
            ack_q <= 1'b1;
        end else if (ack_q && !reg_req_i) begin
            ack_q <= 1'b0;
        end
    end

    // register file
    // only en_check and invert are stored from the control word
    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            en_check_q <= 1'b0;
            invert_q   <= 1'b0;
            thresh_q   <= '0;
            clear_q    <= 1'b0;
            for (int k = 0; k < Nti; k++) begin
                offset_q[k] <= '0;
            end
        end else begin
            clear_q <= 1'b0;
            if (wr_en) begin
                case (reg_addr_i)
                    ADDR_CTRL: begin
                        en_check_q <= wr_word.ctrl.en_check;
                        invert_q   <= wr_word.ctrl.invert;
                        // one-cycle pulse to the checker
                        clear_q    <= wr_word.ctrl.clear_cnt;
                    end
                    ADDR_THRESH:  thresh_q    <= wr_word.value;
                    ADDR_OFFSET0: offset_q[0] <= wr_word.value;
                    ADDR_OFFSET1: offset_q[1] <= wr_word.value;
                    ADDR_OFFSET2: offset_q[2] <= wr_word.value;
                    ADDR_OFFSET3: offset_q[3] <= wr_word.value;
                    // counters are read only
                    ADDR_TOTAL, ADDR_ERRORS: begin
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        rd_word = '0;
        case (reg_addr_i)
            ADDR_CTRL: begin
                rd_word.ctrl.en_check = en_check_q;
                rd_word.ctrl.invert   = invert_q;
            end
            ADDR_THRESH:  rd_word.value = thresh_q;
            ADDR_OFFSET0: rd_word.value = offset_q[0];
            ADDR_OFFSET1: rd_word.value = offset_q[1];
            ADDR_OFFSET2: rd_word.value = offset_q[2];
            ADDR_OFFSET3: rd_word.value = offset_q[3];
            ADDR_TOTAL:   rd_word       = cfg_o.total_cnt;
            ADDR_ERRORS:  rd_word       = cfg_o.err_cnt;
            default:      rd_word       = '0;
        endcase
    end

    // read data is held while ack is high
    always_ff @(posedge clk_adc_i) begin
        if (start) begin
            rdata_q <= rd_word;
        end
    end

    assign reg_ack_o   = ack_q;
    assign reg_rdata_o = rdata_q;

    // configuration to the datapath
    assign cfg_o.thresh    = thresh_q;
    assign cfg_o.offset    = offset_q;
    assign cfg_o.invert    = invert_q;
    assign cfg_o.en_check  = en_check_q;
    assign cfg_o.clear_cnt = clear_q;

endmodule

`default_nettype wire

// ==== logic/digital_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module digital_core (
    input  wire logic                        clk_adc_i,
    input  wire logic                        reset_i,
    // ADC lanes
    input  wire logic [dcore_pack::Nadc-1:0] adcout_i [dcore_pack::Nti-1:0],
    input  wire logic [dcore_pack::Nti-1:0]  adcout_sign_i,
    // register port
    input  wire logic                        reg_req_i,
    input  wire logic                        reg_we_i,
    input  wire dcore_pack::reg_addr_t       reg_addr_i,
    input  wire logic [dcore_pack::Nreg-1:0] reg_wdata_i,
    output wire logic                        reg_ack_o,
    output wire logic [dcore_pack::Nreg-1:0] reg_rdata_o
);
    import dcore_pack::*;

    // config and counters between regs and datapath
    dcore_cfg_intf cfg ();

    // sliced bits, two cycles behind the ADC inputs
    wire logic [Nti-1:0] rx_bits;

    dcore_regs regs_i (
        .clk_adc_i   (clk_adc_i),
        .reset_i     (reset_i),
        .reg_req_i   (reg_req_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_ack_o   (reg_ack_o),
        .reg_rdata_o (reg_rdata_o),
        .cfg_o       (cfg)
    );

    adc_unfold_slice unfold_i (
        .clk_adc_i     (clk_adc_i),
        .reset_i       (reset_i),
        .adcout_i      (adcout_i),
        .adcout_sign_i (adcout_sign_i),
        .cfg_i         (cfg),
        .rx_bits_o     (rx_bits)
    );

    prbs_checker prbs_checker_i (
        .clk_adc_i (clk_adc_i),
        .reset_i   (reset_i),
        .rx_bits_i (rx_bits),
        .cfg_i     (cfg)
    );

endmodule

`default_nettype wire

// ==== verif/digital_core_tb.sv ====
`timescale 1ns/1ns

module digital_core_tb;
    import dcore_pack::*;

    // handshake wait bound in cycles
    localparam int hs_limit   = 20;
    // serial bit index of the first flipped bit and the spacing between flips
    localparam int flip_first = 11;
    localparam int flip_step  = 13;

    logic                   clk_adc;
    logic                   reset;
    logic [Nadc-1:0]        adcout [Nti-1:0];
    logic [Nti-1:0]         adcout_sign;
    logic                   reg_req;
    logic                   reg_we;
    reg_addr_t              reg_addr;
    logic [Nreg-1:0]        reg_wdata;
    logic                   reg_ack;
    logic [Nreg-1:0]        reg_rdata;

    // slicer setup as last written and followed by the drive
    logic signed [Nreg-1:0] thresh_sh;
    logic signed [Nreg-1:0] offset_sh [Nti-1:0];
    ctrl_t                  ctrl_sh;
    logic                   follow_cfg;
    logic                   assume_inv;
    // reference PRBS7 history with bit 0 oldest
    logic [Nprbs-1:0]       prbs_hist;

    digital_core dut0 (
        .clk_adc_i     (clk_adc),
        .reset_i       (reset),
        .adcout_i      (adcout),
        .adcout_sign_i (adcout_sign),
        .reg_req_i     (reg_req),
        .reg_we_i      (reg_we),
        .reg_addr_i    (reg_addr),
        .reg_wdata_i   (reg_wdata),
        .reg_ack_o     (reg_ack),
        .reg_rdata_o   (reg_rdata)
    );

    always #50 clk_adc = ~clk_adc;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_reg_word(input reg_addr_t addr, input reg_word_u expected,
                                    input reg_word_u actual);
        if (actual !== expected) begin
            $display("Mismatch reg_rdata_o addr %0d expected %h actual %h",
                     addr, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_count(input reg_addr_t addr, input logic [Nreg-1:0] expected,
                                 input logic [Nreg-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch reg_rdata_o addr %0d expected %h actual %h",
                     addr, expected, actual);
            abort_run();
        end
    endtask

    // one four-phase transfer that returns on the edge where ack is seen low again
    task automatic reg_cycle(input logic we, input reg_addr_t addr,
                             input logic [Nreg-1:0] wdata, output logic [Nreg-1:0] rdata);
        int waited;
        @(posedge clk_adc);
        reg_req   <= 1'b1;
        reg_we    <= we;
        reg_addr  <= addr;
        reg_wdata <= wdata;
        waited = 0;
        do begin
            @(posedge clk_adc);
            waited++;
        end while (!reg_ack && waited < hs_limit);
        if (!reg_ack) begin
            $display("register handshake timed out waiting for ack");
            abort_run();
        end
        rdata = reg_rdata;
        reg_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk_adc);
            waited++;
        end while (reg_ack && waited < hs_limit);
        if (reg_ack) begin
            $display("register handshake timed out waiting for ack release");
            abort_run();
        end
    endtask

    // next four bits of x^7 + x^6 + 1 with lane 0 first
    task automatic next_vector(output logic [Nti-1:0] bits);
        for (int k = 0; k < Nti; k++) begin
            bits[k] = prbs_hist[0] ^ prbs_hist[1];
            prbs_hist = {bits[k], prbs_hist[Nprbs-1:1]};
        end
    endtask

    // sign and magnitude whose corrected code lands 8 to 71 away from the threshold
    function automatic logic [Nadc:0] lane_code(input logic bit_v, input int lane);
        int   t;
        int   off;
        int   code;
        int   unf;
        logic above;
        t   = 0;
        off = 0;
        if (follow_cfg) begin
            t   = $signed(thresh_sh[Nadc:0]);
            off = $signed(offset_sh[lane][Nadc:0]);
        end
        above = bit_v ^ assume_inv;
        code  = above ? t + 8 + ($urandom % 64) : t - 8 - ($urandom % 64);
        unf   = code + off;
        if (unf >= 0) begin
            return {1'b1, unf[Nadc-1:0]};
        end
        unf = -unf;
        return {1'b0, unf[Nadc-1:0]};
    endfunction

    function automatic bit is_flipped(input int idx, input int flips);
        return idx >= flip_first && (idx - flip_first) % flip_step == 0
               && (idx - flip_first) / flip_step < flips;
    endfunction

    // v0 is driven two cycles before en_check rises so the warm-up sees v0 and v1
    // and the disable lands right after the last vector is checked
    task automatic run_stream(input int n, input int flips);
        logic [Nreg-1:0] unused;
        reg_word_u       ctrl_word;
        if (n < 8 || (flips > 0 && flip_first + flip_step * (flips - 1) + Nprbs >= 4 * n)) begin
            $display("stream command too short for its flipped bits");
            abort_run();
        end
        ctrl_word = '0;
        ctrl_word.ctrl = ctrl_sh;
        fork
            begin
                logic [Nti-1:0] bits;
                logic [Nadc:0]  lc;
                for (int v = 0; v < n; v++) begin
                    @(posedge clk_adc);
                    next_vector(bits);
                    for (int k = 0; k < Nti; k++) begin
                        if (is_flipped(Nti * v + k, flips)) begin
                            bits[k] = ~bits[k];
                        end
                        lc = lane_code(bits[k], k);
                        adcout_sign[k] <= lc[Nadc];
                        adcout[k]      <= lc[Nadc-1:0];
                    end
                end
            end
            begin
                @(posedge clk_adc);
                ctrl_word.ctrl.en_check = 1'b1;
                reg_cycle(1'b1, ADDR_CTRL, ctrl_word, unused);
                repeat (n - 5) @(posedge clk_adc);
                ctrl_word.ctrl.en_check = 1'b0;
                reg_cycle(1'b1, ADDR_CTRL, ctrl_word, unused);
            end
        join
    endtask

    initial begin
        int              fd;
        int              got;
        int              ch;
        logic [7:0]      cmd;
        logic [31:0]     arg_a;
        logic [31:0]     arg_b;
        logic [Nreg-1:0] rdata;
        reg_word_u       word;
        got = $urandom(32'h4924_6dbc);
        clk_adc     = 1'b0;
        reset       = 1'b1;
        adcout_sign = '0;
        reg_req     = 1'b0;
        reg_we      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        thresh_sh   = '0;
        ctrl_sh     = '0;
        follow_cfg  = 1'b0;
        assume_inv  = 1'b0;
        prbs_hist   = '1;
        for (int k = 0; k < Nti; k++) begin
            adcout[k]    = '0;
            offset_sh[k] = '0;
        end
        repeat (3) @(posedge clk_adc);
        reset <= 1'b0;

        fd = $fopen("verif/digital_core_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file");
            abort_run();
        end
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "#") begin
                do begin
                    ch = $fgetc(fd);
                end while (ch != "\n" && ch != -1);
            end else if (cmd == "O") begin
                got = $fscanf(fd, "%h", arg_a);
                if (got != 1) begin
                    $display("golden file line has missing fields");
                    abort_run();
                end
                follow_cfg = arg_a[0];
                assume_inv = arg_a[1];
            end else begin
                got = $fscanf(fd, "%h %h", arg_a, arg_b);
                if (got != 2) begin
                    $display("golden file line has missing fields");
                    abort_run();
                end
                word = arg_b[Nreg-1:0];
                case (cmd)
                    "W": begin
                        reg_cycle(1'b1, arg_a[2:0], word, rdata);
                        case (arg_a[2:0])
                            ADDR_CTRL:    ctrl_sh.invert = word.ctrl.invert;
                            ADDR_THRESH:  thresh_sh      = word.value;
                            ADDR_OFFSET0: offset_sh[0]   = word.value;
                            ADDR_OFFSET1: offset_sh[1]   = word.value;
                            ADDR_OFFSET2: offset_sh[2]   = word.value;
                            ADDR_OFFSET3: offset_sh[3]   = word.value;
                            default: begin
                            end
                        endcase
                    end
                    "R": begin
                        reg_cycle(1'b0, arg_a[2:0], '0, rdata);
                        if (arg_a[2:0] == ADDR_TOTAL || arg_a[2:0] == ADDR_ERRORS) begin
                            compare_count(arg_a[2:0], word, rdata);
                        end else begin
                            compare_reg_word(arg_a[2:0], word, rdata);
                        end
                    end
                    "P": run_stream(arg_a, arg_b);
                    default: begin
                        $display("unknown command in the golden file");
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verif/digital_core_golden.txt ====
# command letter, then hex fields
# W addr data | R addr expected | P vectors flips | O mode (bit0 follow setup, bit1 invert)
R 0 0000
R 1 0000
R 2 0000
R 3 0000
R 4 0000
R 5 0000
R 6 0000
R 7 0000
# only en_check and invert read back
W 0 ffff
R 0 0003
W 0 0004
R 0 0000
R 6 0000
R 7 0000
# clean stream, 4 * (10 - 2) bits
O 0
P 0a 0
R 6 0020
R 7 0000
# two isolated flips, three errors each
P 14 2
R 6 0068
R 7 0006
W 6 ffff
W 7 1234
R 6 0068
R 7 0006
W 1 0010
W 2 fff0
W 3 000c
W 4 0020
W 5 ffe8
R 1 0010
R 2 fff0
R 3 000c
R 4 0020
R 5 ffe8
# invert on, counters cleared
W 0 0006
R 0 0002
R 6 0000
R 7 0000
O 3
P 0c 0
R 6 0028
R 7 0000
# drive ignores invert, every counted bit fails
O 1
P 0a 0
R 6 0048
R 7 0020
W 0 0006
R 6 0000
R 7 0000
O 3
P 08 1
R 6 0018
R 7 0003

// ==== digital_core.f ====
logic/dcore_pack.sv
logic/dcore_cfg_intf.sv
logic/adc_unfold_slice.sv
logic/prbs_checker.sv
logic/dcore_regs.sv
logic/digital_core.sv
verif/digital_core_tb.sv

// ==== Bender.yml ====
package:
  name: digital_core

sources:
  # RTL in compile order
  - logic/dcore_pack.sv
  - logic/dcore_cfg_intf.sv
  - logic/adc_unfold_slice.sv
  - logic/prbs_checker.sv
  - logic/dcore_regs.sv
  - logic/digital_core.sv
  - target: test
    files:
      - verif/digital_core_tb.sv
